//--- Bender.yml
package:
  name: mmix_decode

sources:
  - files:
      - logic/mmix_pkg.sv
      - logic/opcode_table.sv
      - logic/operand_spec.sv
      - logic/dest_rename.sv
      - logic/stack_regs.sv
      - logic/mmix_decode.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_mmix_decode.sv

//--- compile.f
+incdir+tests
logic/mmix_pkg.sv
logic/opcode_table.sv
logic/operand_spec.sv
logic/dest_rename.sv
logic/stack_regs.sv
logic/mmix_decode.sv
tests/tb_mmix_decode.sv

//--- tests/tb_ref_model.svh
/*
 * expected decode records, included inside the testbench module
 * tracks G, L, O and S itself, so predict must be called once per presentation
 * offsets of odd (backward) relative opcodes have 2^24 or 2^16 taken off
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

mmix_pkg::reg_num_t   m_g, m_l;   // model stack pointers
mmix_pkg::stack_ptr_t m_o, m_s;
mmix_pkg::op_class_t  exp_class;
mmix_pkg::spec_kind_t exp_y_kind, exp_z_kind, exp_b_kind, exp_x_kind;
mmix_pkg::word_t      exp_y_val, exp_z_val, exp_b_val, exp_a_val, exp_target;
mmix_pkg::reg_num_t   exp_x_addr;
logic                 exp_ren_x, exp_ren_a, exp_ctl, exp_reissue;

function automatic mmix_pkg::reg_num_t ring_slot(input mmix_pkg::reg_num_t n);
	mmix_pkg::stack_ptr_t sum;
	sum = m_o + mmix_pkg::stack_ptr_t'(n);
	return sum[7:0]; // ring of 256
endfunction

function automatic mmix_pkg::spec_kind_t kind_of(input mmix_pkg::reg_num_t n);
	return (n >= m_g) ? mmix_pkg::spec_global : mmix_pkg::spec_local;
endfunction

function automatic mmix_pkg::word_t val_of(input mmix_pkg::reg_num_t n);
	return (n >= m_g) ? mmix_pkg::word_t'(n) : mmix_pkg::word_t'(ring_slot(n));
endfunction

task automatic predict(input mmix_pkg::inst_t i, input mmix_pkg::word_t at);
	mmix_pkg::reg_num_t   op, x, y, z;
	logic                 yi, yr, zi, zr, xs, xd, rel, ctl, yz_grp, full, xg;
	mmix_pkg::word_t      off;
	mmix_pkg::stack_ptr_t gap;
	{op, x, y, z} = i;
	{yi, yr, zi, zr, xs, xd, rel, ctl, yz_grp} = '0;
	exp_class = mmix_pkg::cls_trap;
	if (op >= 8'h20 && op <= 8'h27) begin
		exp_class = mmix_pkg::cls_addsub;
		yz_grp = 1;
		xd = 1;
	end else if (op >= 8'h30 && op <= 8'h37) begin
		exp_class = mmix_pkg::cls_cmp;
		yz_grp = 1;
		xd = 1;
	end else if (op >= 8'h38 && op <= 8'h3F) begin
		exp_class = mmix_pkg::cls_shift;
		yz_grp = 1;
		xd = 1;
	end else if (op >= 8'h40 && op <= 8'h4F) begin
		exp_class = mmix_pkg::cls_br;
		xs = 1;
		rel = 1;
	end else if (op >= 8'h80 && op <= 8'h8F) begin
		exp_class = mmix_pkg::cls_ld;
		yz_grp = 1;
		xd = 1;
	end else if (op >= 8'hA0 && op <= 8'hAF) begin
		exp_class = mmix_pkg::cls_st;
		yz_grp = 1;
		xs = 1; // stored data is $X
	end else if (op >= 8'hC0 && op <= 8'hCF) begin
		exp_class = mmix_pkg::cls_logic;
		yz_grp = 1;
		xd = 1;
	end else if (op >= 8'hE0 && op <= 8'hE3) begin
		exp_class = mmix_pkg::cls_set;
		xd = 1;
	end else if (op >= 8'hE4 && op <= 8'hE6) begin
		exp_class = mmix_pkg::cls_inc;
		xs = 1;
		xd = 1;
	end else if (op == 8'hF0 || op == 8'hF1) begin
		exp_class = mmix_pkg::cls_jmp;
		rel = 1;
		ctl = 1;
	end else if (op == 8'hF2 || op == 8'hF3) begin
		exp_class = mmix_pkg::cls_pushj;
		xd = 1;
		rel = 1;
		ctl = 1;
	end else begin
		yr = 1; // behaves like TRAP
		zr = 1;
		ctl = 1;
	end
	if (yz_grp) begin
		yr = 1;
		zi = op[0];
		zr = !op[0];
	end
	if (exp_class == mmix_pkg::cls_cmp && op[2]) begin // NEG
		yr = 0;
		yi = 1;
	end

	if (op[7:1] == 7'h78)
		off = mmix_pkg::word_t'(i[23:0]) - (op[0] ? 64'h100_0000 : 64'd0);
	else
		off = mmix_pkg::word_t'(i[15:0]) - (op[0] ? 64'h1_0000 : 64'd0);
	exp_target = at + (off << 2);

	if (rel) begin
		exp_y_kind = mmix_pkg::spec_imm;
		exp_y_val = at + 64'd4;
	end else if (exp_class == mmix_pkg::cls_inc) begin // INCxx group reads $X as Y
		exp_y_kind = kind_of(x);
		exp_y_val = val_of(x);
	end else if (yi) begin
		exp_y_kind = mmix_pkg::spec_imm;
		exp_y_val = mmix_pkg::word_t'(y);
	end else if (yr) begin
		exp_y_kind = kind_of(y);
		exp_y_val = val_of(y);
	end else begin
		exp_y_kind = mmix_pkg::spec_none;
		exp_y_val = '0;
	end

	exp_z_kind = mmix_pkg::spec_imm;
	if (rel)
		exp_z_val = exp_target;
	else if (exp_class == mmix_pkg::cls_set || exp_class == mmix_pkg::cls_inc)
		exp_z_val = mmix_pkg::word_t'(i[15:0]) << (16 * (3 - op[1:0])); // wyde into place
	else if (zi)
		exp_z_val = mmix_pkg::word_t'(z);
	else if (zr) begin
		exp_z_kind = kind_of(z);
		exp_z_val = val_of(z);
	end else begin
		exp_z_kind = mmix_pkg::spec_none;
		exp_z_val = '0;
	end

	exp_b_kind = xs ? kind_of(x) : mmix_pkg::spec_none;
	exp_b_val = xs ? val_of(x) : '0;

	gap = m_s - m_o - mmix_pkg::stack_ptr_t'(m_l) - 62'd1;
	full = (gap[7:0] == 8'd0);
	xg = (x >= m_g);
	{exp_ren_x, exp_ren_a, exp_reissue} = '0;
	exp_x_kind = mmix_pkg::spec_none;
	exp_x_addr = '0;
	exp_a_val = '0;
	if ((xd && x >= m_l && !xg) || (exp_class == mmix_pkg::cls_pushj && xg && full)) begin
		exp_reissue = 1;
		if (full) begin
			exp_class = mmix_pkg::cls_incgamma;
			m_s = m_s + 62'd1;
		end else begin
			exp_class = mmix_pkg::cls_incrl;
			exp_ren_x = 1;
			exp_x_kind = mmix_pkg::spec_local;
			exp_x_addr = ring_slot(m_l);
			m_l = m_l + 8'd1;
		end
	end else if (exp_class == mmix_pkg::cls_pushj) begin
		exp_ren_x = 1;
		exp_x_kind = mmix_pkg::spec_local;
		exp_x_addr = ring_slot(xg ? m_l : x); // hole slot
		exp_ren_a = 1;
		exp_a_val = at + 64'd4;
		if (xg) begin
			m_o = m_o + mmix_pkg::stack_ptr_t'(m_l) + 62'd1;
			m_l = '0;
		end else begin
			m_o = m_o + mmix_pkg::stack_ptr_t'(x) + 62'd1;
			m_l = m_l - x - 8'd1;
		end
	end else if (xd) begin
		exp_ren_x = 1;
		exp_x_kind = xg ? mmix_pkg::spec_global : mmix_pkg::spec_local;
		exp_x_addr = xg ? x : ring_slot(x);
	end
	exp_ctl = ctl && !exp_reissue;
endtask

`endif

//--- tests/tb_mmix_decode.sv
/*
 * testbench for mmix_decode, directed list then 300 random words (seed 23)
 * records are checked by concurrent assertions one cycle after each strobe
 * target is only compared when ctl_change is expected
 */
`timescale 1ns/1ns
`default_nettype none

module tb_mmix_decode;

	logic clk, arst_n, inst_valid, set_g;
	mmix_pkg::inst_t    inst;
	mmix_pkg::word_t    loc;
	mmix_pkg::reg_num_t g_value;
	logic out_valid, ren_x, ren_a, ctl_change, reissue;
	mmix_pkg::op_class_t  out_class;
	mmix_pkg::spec_kind_t y_kind, z_kind, b_kind, x_kind;
	mmix_pkg::word_t      y_val, z_val, b_val, a_val, target;
	mmix_pkg::reg_num_t   x_addr, reg_g, reg_l;
	mmix_pkg::stack_ptr_t reg_o, reg_s;
	int seed, cycles, cycle_limit;

	`include "tb_ref_model.svh"

	// expected record held for the cycle after the strobe
	logic c_valid, c_ren_x, c_ren_a, c_ctl, c_reissue;
	mmix_pkg::op_class_t  c_class;
	mmix_pkg::spec_kind_t c_y_kind, c_z_kind, c_b_kind, c_x_kind;
	mmix_pkg::word_t      c_y_val, c_z_val, c_b_val, c_a_val, c_target;
	mmix_pkg::reg_num_t   c_x_addr, c_g, c_l;
	mmix_pkg::stack_ptr_t c_o, c_s;

	mmix_decode uut (.*);

	initial begin
		clk = 0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			c_valid <= 0;
		else
			c_valid <= inst_valid;
		if (inst_valid) begin // model already stepped at drive time
			{c_class, c_ren_x, c_ren_a, c_ctl, c_reissue} <=
				{exp_class, exp_ren_x, exp_ren_a, exp_ctl, exp_reissue};
			{c_y_kind, c_z_kind, c_b_kind, c_x_kind} <=
				{exp_y_kind, exp_z_kind, exp_b_kind, exp_x_kind};
			{c_y_val, c_z_val, c_b_val} <= {exp_y_val, exp_z_val, exp_b_val};
			{c_a_val, c_target, c_x_addr} <= {exp_a_val, exp_target, exp_x_addr};
			{c_g, c_l, c_o, c_s} <= {m_g, m_l, m_o, m_s};
		end
	end

	task automatic report_value(input string name, input logic [63:0] expv, actv);
		$display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expv, actv);
		$display("Simulation failed");
		$fatal(1);
	endtask

	a_valid: assert property (@(posedge clk) disable iff (!arst_n) out_valid == c_valid)
		else report_value("out_valid", $sampled(c_valid), $sampled(out_valid));
	a_idle: assert property (@(posedge clk) disable iff (!arst_n)
		!c_valid |-> !(ren_x || ren_a || ctl_change || reissue))
		else report_value("idle controls", 0, $sampled({ren_x, ren_a, ctl_change, reissue}));
	a_class: assert property (@(posedge clk) c_valid |-> out_class == c_class)
		else report_value("out_class", $sampled(c_class), $sampled(out_class));
	a_y_kind: assert property (@(posedge clk) c_valid |-> y_kind == c_y_kind)
		else report_value("y_kind", $sampled(c_y_kind), $sampled(y_kind));
	a_y_val: assert property (@(posedge clk) c_valid |-> y_val == c_y_val)
		else report_value("y_val", $sampled(c_y_val), $sampled(y_val));
	a_z_kind: assert property (@(posedge clk) c_valid |-> z_kind == c_z_kind)
		else report_value("z_kind", $sampled(c_z_kind), $sampled(z_kind));
	a_z_val: assert property (@(posedge clk) c_valid |-> z_val == c_z_val)
		else report_value("z_val", $sampled(c_z_val), $sampled(z_val));
	a_b_kind: assert property (@(posedge clk) c_valid |-> b_kind == c_b_kind)
		else report_value("b_kind", $sampled(c_b_kind), $sampled(b_kind));
	a_b_val: assert property (@(posedge clk) c_valid |-> b_val == c_b_val)
		else report_value("b_val", $sampled(c_b_val), $sampled(b_val));
	a_ren_x: assert property (@(posedge clk) c_valid |-> ren_x == c_ren_x)
		else report_value("ren_x", $sampled(c_ren_x), $sampled(ren_x));
	a_x_kind: assert property (@(posedge clk) c_valid |-> x_kind == c_x_kind)
		else report_value("x_kind", $sampled(c_x_kind), $sampled(x_kind));
	a_x_addr: assert property (@(posedge clk) c_valid |-> x_addr == c_x_addr)
		else report_value("x_addr", $sampled(c_x_addr), $sampled(x_addr));
	a_ren_a: assert property (@(posedge clk) c_valid |-> ren_a == c_ren_a)
		else report_value("ren_a", $sampled(c_ren_a), $sampled(ren_a));
	a_a_val: assert property (@(posedge clk) c_valid |-> a_val == c_a_val)
		else report_value("a_val", $sampled(c_a_val), $sampled(a_val));
	a_ctl: assert property (@(posedge clk) c_valid |-> ctl_change == c_ctl)
		else report_value("ctl_change", $sampled(c_ctl), $sampled(ctl_change));
	a_target: assert property (@(posedge clk) (c_valid && c_ctl) |-> target == c_target)
		else report_value("target", $sampled(c_target), $sampled(target));
	a_reissue: assert property (@(posedge clk) c_valid |-> reissue == c_reissue)
		else report_value("reissue", $sampled(c_reissue), $sampled(reissue));
	a_reg_g: assert property (@(posedge clk) c_valid |-> reg_g == c_g)
		else report_value("reg_g", $sampled(c_g), $sampled(reg_g));
	a_reg_l: assert property (@(posedge clk) c_valid |-> reg_l == c_l)
		else report_value("reg_l", $sampled(c_l), $sampled(reg_l));
	a_reg_o: assert property (@(posedge clk) c_valid |-> reg_o == c_o)
		else report_value("reg_o", $sampled(c_o), $sampled(reg_o));
	a_reg_s: assert property (@(posedge clk) c_valid |-> reg_s == c_s)
		else report_value("reg_s", $sampled(c_s), $sampled(reg_s));

	// fixed budget, twice the issued words plus slack for reset and idle cycles
	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: decoder run took too many cycles");
			$display("Simulation failed");
			$fatal(1);
		end
	end

	task automatic present(input mmix_pkg::inst_t i, input mmix_pkg::word_t at);
		@(posedge clk);
		#2;
		predict(i, at);
		inst = i;
		loc = at;
		inst_valid = 1;
	endtask

	task automatic issue(input mmix_pkg::inst_t i, input mmix_pkg::word_t at);
		present(i, at);
		while (exp_reissue) // inserted op, same instruction again
			present(i, at);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#2 inst_valid = 0;
	endtask

	task automatic load_g(input mmix_pkg::reg_num_t v);
		idle_cycle();
		set_g = 1;
		g_value = v;
		@(posedge clk);
		#2 set_g = 0;
		m_g = v;
	endtask

	initial begin
		mmix_pkg::word_t r_loc;
		seed = 23;
		cycles = 0;
		cycle_limit = 2 * (21 + 258 + 2 + 300) + 50; // directed, ring fill, G pair, random
		{arst_n, inst_valid, set_g} = '0;
		inst = '0;
		loc = '0;
		g_value = 8'd0;
		m_g = mmix_pkg::G_RESET;
		{m_l, m_o, m_s} = '0;
		repeat (2) @(posedge clk);
		#2 arst_n = 1;

		issue(32'h20010203, 64'h1000); // marginal $1 twice, then ADD
		issue(32'h21000105, 64'h1004);
		issue(32'h34000107, 64'h1008); // NEG
		issue(32'h3B010009, 64'h100C);
		issue(32'h30000101, 64'h1010);
		issue(32'hE0001234, 64'h1014); // SETH..SETL
		issue(32'hE1001234, 64'h1018);
		issue(32'hE2001234, 64'h101C);
		issue(32'hE3001234, 64'h1020);
		issue(32'hE400ABCD, 64'h1024);
		issue(32'h8C0001F0, 64'h1028);
		issue(32'hAD0101FF, 64'h102C);
		issue(32'hC9000133, 64'h1030);
		issue(32'h42010010, 64'h1034); // branch forward
		issue(32'h4301FFF0, 64'h1038); // branch backward
		issue(32'hF0000020, 64'h2000);
		issue(32'hF1FFFFF0, 64'h2004);
		issue(32'h00010203, 64'h2008); // traps
		issue(32'hFE000000, 64'h200C);
		issue(32'h10020304, 64'h2010);
		issue(32'hF2010008, 64'h2014); // PUSHJ $1 inside the frame
		for (int k = 0; k < 258; k++)
			issue(32'hF2FF0004, 64'h3000 + 4 * k); // fills ring, then incgamma
		load_g(8'd40);
		issue(32'h20320102, 64'h4000); // $50 now global
		issue(32'h20230102, 64'h4004); // $35 marginal under G=40
		for (int k = 0; k < 300; k++) begin
			r_loc = {$random(seed), $random(seed)};
			r_loc[1:0] = 2'b00;
			issue($random(seed), r_loc);
		end
		idle_cycle();
		repeat (3) @(posedge clk);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/mmix_decode.sv
/*
 * MMIX dispatch decoder, top level
 * one record per inst_valid strobe, registered, out_valid one cycle later
 * on reissue the fetch side must present the same instruction again next
 * set_g and inst_valid are never raised together
 */
`timescale 1ns/1ns
`default_nettype none

module mmix_decode (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 inst_valid,
	input  mmix_pkg::inst_t      inst,
	input  mmix_pkg::word_t      loc,
	input  logic                 set_g,
	input  mmix_pkg::reg_num_t   g_value,
	output logic                 out_valid,
	output mmix_pkg::op_class_t  out_class,
	output mmix_pkg::spec_kind_t y_kind,
	output mmix_pkg::spec_kind_t z_kind,
	output mmix_pkg::spec_kind_t b_kind,
	output mmix_pkg::word_t      y_val,
	output mmix_pkg::word_t      z_val,
	output mmix_pkg::word_t      b_val,
	output logic                 ren_x,
	output mmix_pkg::spec_kind_t x_kind,
	output mmix_pkg::reg_num_t   x_addr,
	output logic                 ren_a,
	output mmix_pkg::word_t      a_val,
	output logic                 ctl_change,
	output mmix_pkg::word_t      target,
	output logic                 reissue,
	output mmix_pkg::reg_num_t   reg_g,
	output mmix_pkg::reg_num_t   reg_l,
	output mmix_pkg::stack_ptr_t reg_o,
	output mmix_pkg::stack_ptr_t reg_s
);

	mmix_pkg::op_class_t  t_class, c_class;  // table class, class after insertion
	mmix_pkg::flags_t     t_flags;
	mmix_pkg::spec_kind_t c_y_kind, c_z_kind, c_b_kind, c_x_kind;
	mmix_pkg::word_t      c_y_val, c_z_val, c_b_val, c_a_val, c_target;
	mmix_pkg::reg_num_t   c_x_addr, n_l;
	mmix_pkg::stack_ptr_t n_o, n_s;
	logic                 c_ren_x, c_ren_a, c_reissue, c_ctl;

	opcode_table u_table (.op(inst[31:24]), .op_class(t_class), .flags(t_flags));

	operand_spec u_spec (
		.inst(inst), .loc(loc), .flags(t_flags), .reg_g(reg_g), .reg_o(reg_o),
		.y_kind(c_y_kind), .y_val(c_y_val), .z_kind(c_z_kind), .z_val(c_z_val),
		.b_kind(c_b_kind), .b_val(c_b_val), .target(c_target)
	);

	dest_rename u_rename (
		.op_class(t_class), .flags(t_flags), .xx(inst[23:16]), .loc(loc),
		.reg_g(reg_g), .reg_l(reg_l), .reg_o(reg_o), .reg_s(reg_s),
		.new_class(c_class), .ren_x(c_ren_x), .x_kind(c_x_kind), .x_addr(c_x_addr),
		.ren_a(c_ren_a), .a_val(c_a_val), .next_l(n_l), .next_o(n_o), .next_s(n_s),
		.reissue(c_reissue)
	);

	stack_regs u_stack (
		.clk(clk), .arst_n(arst_n), .commit(inst_valid),
		.next_l(n_l), .next_o(n_o), .next_s(n_s), .set_g(set_g), .g_value(g_value),
		.reg_g(reg_g), .reg_l(reg_l), .reg_o(reg_o), .reg_s(reg_s)
	);

	// an inserted op stands in for the instruction, so no redirect yet
	assign c_ctl = t_flags[mmix_pkg::FLAG_CTL_CHANGE] && !c_reissue;

	always_ff @(posedge clk or negedge arst_n) begin // control bits, one-cycle pulses
		if (!arst_n) begin
			out_valid <= 1'b0;
			ren_x <= 1'b0;
			ren_a <= 1'b0;
			ctl_change <= 1'b0;
			reissue <= 1'b0;
		end else begin
			out_valid <= inst_valid;
			ren_x <= inst_valid && c_ren_x;
			ren_a <= inst_valid && c_ren_a;
			ctl_change <= inst_valid && c_ctl;
			reissue <= inst_valid && c_reissue;
		end
	end

	always_ff @(posedge clk) begin // record payload, held between strobes
		if (inst_valid) begin
			out_class <= c_class;
			y_kind <= c_y_kind;
			y_val <= c_y_val;
			z_kind <= c_z_kind;
			z_val <= c_z_val;
			b_kind <= c_b_kind;
			b_val <= c_b_val;
			x_kind <= c_x_kind;
			x_addr <= c_x_addr;
			a_val <= c_a_val;
			target <= c_target;
		end
	end

	valid_follows: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid == $past(inst_valid));

	// G never drops below G_MIN, so a global rename cannot hit rJ
	no_rj_alias: assert property (@(posedge clk) disable iff (!arst_n)
		(ren_x && x_kind == mmix_pkg::spec_global) |-> x_addr != mmix_pkg::REG_RJ);

endmodule

`default_nettype wire

//--- logic/stack_regs.sv
/*
 * register-stack pointers G, L, O and S
 * commit takes next_l/o/s; set_g loads G and must not coincide with commit
 * G comes out of reset as 255, leaving the whole ring local
 */
`timescale 1ns/1ns
`default_nettype none

module stack_regs (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 commit,
	input  mmix_pkg::reg_num_t   next_l,
	input  mmix_pkg::stack_ptr_t next_o,
	input  mmix_pkg::stack_ptr_t next_s,
	input  logic                 set_g,
	input  mmix_pkg::reg_num_t   g_value,
	output mmix_pkg::reg_num_t   reg_g,
	output mmix_pkg::reg_num_t   reg_l,
	output mmix_pkg::stack_ptr_t reg_o,
	output mmix_pkg::stack_ptr_t reg_s
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reg_g <= mmix_pkg::G_RESET;
			reg_l <= '0;
			reg_o <= '0;
			reg_s <= '0;
		end else begin
			if (set_g)
				reg_g <= g_value;
			if (commit) begin // every decode, inserted ops included
				reg_l <= next_l;
				reg_o <= next_o;
				reg_s <= next_s;
			end
		end
	end

	// $0..$31 stay local-capable whatever software writes to rG
	g_min_check: assert property (@(posedge clk) disable iff (!arst_n)
		set_g |-> g_value >= mmix_pkg::G_MIN);

	// incrl only grows L up to the marginal bound
	l_below_g: assert property (@(posedge clk) disable iff (!arst_n)
		reg_l <= reg_g);

	// incgamma has to spill before the ring wraps onto unsaved entries
	ring_bound: assert property (@(posedge clk) disable iff (!arst_n)
		(reg_o + mmix_pkg::stack_ptr_t'(reg_l) - reg_s) < mmix_pkg::LRING_SIZE);

endmodule

`default_nettype wire

//--- logic/dest_rename.sv
/*
 * destination renaming and register-stack bookkeeping, combinational
 * a marginal X (L <= X < G) is replaced by incrl, or by incgamma when the ring is full
 * an inserted operation raises reissue and the same instruction must come back next
 * PUSHJ renames the hole slot O+X, with X taken as L when X >= G
 */
`timescale 1ns/1ns
`default_nettype none

module dest_rename (
	input  mmix_pkg::op_class_t  op_class,
	input  mmix_pkg::flags_t     flags,
	input  mmix_pkg::reg_num_t   xx,
	input  mmix_pkg::word_t      loc,
	input  mmix_pkg::reg_num_t   reg_g,
	input  mmix_pkg::reg_num_t   reg_l,
	input  mmix_pkg::stack_ptr_t reg_o,
	input  mmix_pkg::stack_ptr_t reg_s,
	output mmix_pkg::op_class_t  new_class,
	output logic                 ren_x,
	output mmix_pkg::spec_kind_t x_kind,
	output mmix_pkg::reg_num_t   x_addr,
	output logic                 ren_a,
	output mmix_pkg::word_t      a_val,
	output mmix_pkg::reg_num_t   next_l,
	output mmix_pkg::stack_ptr_t next_o,
	output mmix_pkg::stack_ptr_t next_s,
	output logic                 reissue
);

	mmix_pkg::stack_ptr_t gap;        // free ring entries minus one, mod 256
	logic                 ring_full;
	logic                 x_dest;
	logic                 marginal;   // $X lies between L and G
	logic                 pushj_full; // PUSHJ past G would overrun the ring
	logic                 is_pushj;
	logic                 x_global;
	mmix_pkg::reg_num_t   hole;       // slot that PUSHJ writes

	function automatic mmix_pkg::reg_num_t local_slot(input mmix_pkg::reg_num_t n);
		mmix_pkg::stack_ptr_t sum;
		sum = (reg_o + mmix_pkg::stack_ptr_t'(n)) & mmix_pkg::stack_ptr_t'(mmix_pkg::LRING_MASK);
		return mmix_pkg::reg_num_t'(sum);
	endfunction

	assign gap = reg_s - reg_o - mmix_pkg::stack_ptr_t'(reg_l) - 62'd1;
	assign ring_full = ((gap & mmix_pkg::stack_ptr_t'(mmix_pkg::LRING_MASK)) == '0);
	assign x_dest = flags[mmix_pkg::FLAG_X_DEST];
	assign x_global = (xx >= reg_g);
	assign is_pushj = (op_class == mmix_pkg::cls_pushj);
	assign marginal = x_dest && (xx >= reg_l) && !x_global;
	assign pushj_full = is_pushj && x_global && ring_full;
	assign hole = x_global ? reg_l : xx;

	always_comb begin
		new_class = op_class;
		ren_x = 1'b0;
		x_kind = mmix_pkg::spec_none;
		x_addr = '0;
		ren_a = 1'b0;
		a_val = '0;
		next_l = reg_l;   // pointers hold unless changed below
		next_o = reg_o;
		next_s = reg_s;
		reissue = 1'b0;

		if (marginal || pushj_full) begin
			reissue = 1'b1; // instruction is not consumed
			if (ring_full) begin
				new_class = mmix_pkg::cls_incgamma; // spill slot S, frees one entry
				next_s = reg_s + 62'd1;
			end else begin
				new_class = mmix_pkg::cls_incrl;    // new local O+L, cleared to zero
				ren_x = 1'b1;
				x_kind = mmix_pkg::spec_local;
				x_addr = local_slot(reg_l);
				next_l = reg_l + 8'd1;
			end
		end else if (is_pushj) begin
			ren_x = 1'b1; // hole receives the count of pushed registers
			x_kind = mmix_pkg::spec_local;
			x_addr = local_slot(hole);
			ren_a = 1'b1; // rJ gets the return address
			a_val = loc + 64'd4;
			if (x_global) begin
				next_l = '0;
				next_o = reg_o + mmix_pkg::stack_ptr_t'(reg_l) + 62'd1;
			end else begin
				next_l = reg_l - xx - 8'd1;
				next_o = reg_o + mmix_pkg::stack_ptr_t'(xx) + 62'd1;
			end
		end else if (x_dest) begin
			ren_x = 1'b1; // marginal case excluded above, so X < L or X >= G
			if (x_global) begin
				x_kind = mmix_pkg::spec_global;
				x_addr = xx;
			end else begin
				x_kind = mmix_pkg::spec_local;
				x_addr = local_slot(xx);
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/operand_spec.sv
/*
 * Y, Z and B operand specifiers and the relative target, combinational
 * a register at or above G is global, anything below maps to ring slot (O+n) mod 256
 * the L bound is not checked here, marginal X is handled by dest_rename
 */
`timescale 1ns/1ns
`default_nettype none

module operand_spec (
	input  mmix_pkg::inst_t      inst,
	input  mmix_pkg::word_t      loc,
	input  mmix_pkg::flags_t     flags,
	input  mmix_pkg::reg_num_t   reg_g,
	input  mmix_pkg::stack_ptr_t reg_o,
	output mmix_pkg::spec_kind_t y_kind,
	output mmix_pkg::word_t      y_val,
	output mmix_pkg::spec_kind_t z_kind,
	output mmix_pkg::word_t      z_val,
	output mmix_pkg::spec_kind_t b_kind,
	output mmix_pkg::word_t      b_val,
	output mmix_pkg::word_t      target
);

	mmix_pkg::reg_num_t op, xx, yy, zz;
	mmix_pkg::word_t    jmp_off, br_off; // byte offsets, backward already applied
	logic               wide_imm;        // 0xe0..0xe6, INCL is a trap
	logic               inc_grp;         // 0xe4..0xe6 reads $X as Y

	function automatic mmix_pkg::spec_kind_t reg_kind(input mmix_pkg::reg_num_t n);
		return (n >= reg_g) ? mmix_pkg::spec_global : mmix_pkg::spec_local;
	endfunction

	function automatic mmix_pkg::word_t reg_val(input mmix_pkg::reg_num_t n);
		mmix_pkg::stack_ptr_t slot;
		slot = (reg_o + mmix_pkg::stack_ptr_t'(n)) & mmix_pkg::stack_ptr_t'(mmix_pkg::LRING_MASK);
		return (n >= reg_g) ? mmix_pkg::word_t'(n) : mmix_pkg::word_t'(slot);
	endfunction

	assign {op, xx, yy, zz} = inst;
	assign wide_imm = (op[7:3] == mmix_pkg::OP_SETH[7:3]) && (op[2:0] != 3'b111);
	assign inc_grp = wide_imm && op[2];

	// odd op fills the top with ones, i.e. offset minus 2^24 or 2^16
	assign jmp_off = {{38{op[0]}}, inst[23:0], 2'b00};
	assign br_off = {{46{op[0]}}, inst[15:0], 2'b00};
	assign target = loc + ((op[7:1] == mmix_pkg::OP_JMP[7:1]) ? jmp_off : br_off);

	always_comb begin
		if (flags[mmix_pkg::FLAG_REL_ADDR]) begin
			y_kind = mmix_pkg::spec_imm; // return address for PUSHJ
			y_val = loc + 64'd4;
		end else if (inc_grp) begin
			y_kind = reg_kind(xx);       // INCxx adds to $X
			y_val = reg_val(xx);
		end else if (flags[mmix_pkg::FLAG_Y_IMM]) begin
			y_kind = mmix_pkg::spec_imm;
			y_val = mmix_pkg::word_t'(yy);
		end else if (flags[mmix_pkg::FLAG_Y_REG]) begin
			y_kind = reg_kind(yy);
			y_val = reg_val(yy);
		end else begin
			y_kind = mmix_pkg::spec_none;
			y_val = '0;
		end
	end

	always_comb begin
		z_kind = mmix_pkg::spec_imm;
		z_val = '0;
		if (flags[mmix_pkg::FLAG_REL_ADDR]) begin
			z_val = target;
		end else if (wide_imm) begin
			case (op[1:0]) // H, MH, ML, L wyde
				2'd0: z_val = {inst[15:0], 48'd0};
				2'd1: z_val = {16'd0, inst[15:0], 32'd0};
				2'd2: z_val = {32'd0, inst[15:0], 16'd0};
				default: z_val = {48'd0, inst[15:0]};
			endcase
		end else if (flags[mmix_pkg::FLAG_Z_IMM]) begin
			z_val = mmix_pkg::word_t'(zz);
		end else if (flags[mmix_pkg::FLAG_Z_REG]) begin
			z_kind = reg_kind(zz);
			z_val = reg_val(zz);
		end else begin
			z_kind = mmix_pkg::spec_none;
		end
	end

	// B carries $X for stores, branches and INCxx
	assign b_kind = flags[mmix_pkg::FLAG_X_SRC] ? reg_kind(xx) : mmix_pkg::spec_none;
	assign b_val = flags[mmix_pkg::FLAG_X_SRC] ? reg_val(xx) : '0;

endmodule

`default_nettype wire

//--- logic/opcode_table.sv
/*
 * opcode to class and operand-use flags, purely combinational
 * only the kept groups decode; everything else returns the TRAP entry
 * odd opcodes are the immediate (or backward) variants
 */
`timescale 1ns/1ns
`default_nettype none

module opcode_table (
	input  mmix_pkg::reg_num_t  op,
	output mmix_pkg::op_class_t op_class,
	output mmix_pkg::flags_t    flags
);

	mmix_pkg::flags_t trap_flags; // TRAP reads $Y and $Z and redirects fetch
	mmix_pkg::flags_t yz_flags;   // usual $Y plus $Z or Z immediate

	always_comb begin
		trap_flags = '0;
		trap_flags[mmix_pkg::FLAG_Y_REG] = 1'b1;
		trap_flags[mmix_pkg::FLAG_Z_REG] = 1'b1;
		trap_flags[mmix_pkg::FLAG_CTL_CHANGE] = 1'b1;
	end

	always_comb begin
		yz_flags = '0;
		yz_flags[mmix_pkg::FLAG_Y_REG] = 1'b1;
		yz_flags[mmix_pkg::FLAG_Z_IMM] = op[0];  // odd op takes Z as immediate
		yz_flags[mmix_pkg::FLAG_Z_REG] = ~op[0];
	end

	always_comb begin
		op_class = mmix_pkg::cls_trap;
		flags = trap_flags;
		case (op[7:3])
			5'h04: begin // 0x20..0x27 ADD/SUB family
				op_class = mmix_pkg::cls_addsub;
				flags = yz_flags;
				flags[mmix_pkg::FLAG_X_DEST] = 1'b1;
			end
			5'h06: begin // 0x30..0x37 CMP, NEG
				op_class = mmix_pkg::cls_cmp;
				flags = yz_flags;
				flags[mmix_pkg::FLAG_X_DEST] = 1'b1;
				if (op[2]) begin // NEG has Y as an immediate
					flags[mmix_pkg::FLAG_Y_REG] = 1'b0;
					flags[mmix_pkg::FLAG_Y_IMM] = 1'b1;
				end
			end
			5'h07: begin // 0x38..0x3f shifts
				op_class = mmix_pkg::cls_shift;
				flags = yz_flags;
				flags[mmix_pkg::FLAG_X_DEST] = 1'b1;
			end
			5'h08, 5'h09: begin // 0x40..0x4f branches, not redirected here
				op_class = mmix_pkg::cls_br;
				flags = '0;
				flags[mmix_pkg::FLAG_X_SRC] = 1'b1;   // tested register
				flags[mmix_pkg::FLAG_REL_ADDR] = 1'b1;
			end
			5'h10, 5'h11: begin // 0x80..0x8f loads
				op_class = mmix_pkg::cls_ld;
				flags = yz_flags;
				flags[mmix_pkg::FLAG_X_DEST] = 1'b1;
			end
			5'h14, 5'h15: begin // 0xa0..0xaf stores, $X is the data
				op_class = mmix_pkg::cls_st;
				flags = yz_flags;
				flags[mmix_pkg::FLAG_X_SRC] = 1'b1;
			end
			5'h18, 5'h19: begin // 0xc0..0xcf bitwise logic
				op_class = mmix_pkg::cls_logic;
				flags = yz_flags;
				flags[mmix_pkg::FLAG_X_DEST] = 1'b1;
			end
			5'h1C: begin // 0xe0..0xe7 wide immediates
				if (op[7:2] == mmix_pkg::OP_SETH[7:2]) begin
					op_class = mmix_pkg::cls_set; // SETH..SETL only write $X
					flags = '0;
					flags[mmix_pkg::FLAG_X_DEST] = 1'b1;
				end else if (op[1:0] != 2'b11) begin
					op_class = mmix_pkg::cls_inc; // INCH..INCML, INCL stays trap
					flags = '0;
					flags[mmix_pkg::FLAG_X_SRC] = 1'b1;
					flags[mmix_pkg::FLAG_X_DEST] = 1'b1;
				end
			end
			5'h1E: begin // 0xf0..0xf7, only JMP and PUSHJ kept
				if (op[7:1] == mmix_pkg::OP_JMP[7:1]) begin
					op_class = mmix_pkg::cls_jmp;
					flags = '0;
					flags[mmix_pkg::FLAG_REL_ADDR] = 1'b1;
					flags[mmix_pkg::FLAG_CTL_CHANGE] = 1'b1;
				end else if (op[7:1] == mmix_pkg::OP_PUSHJ[7:1]) begin
					op_class = mmix_pkg::cls_pushj;
					flags = '0;
					flags[mmix_pkg::FLAG_X_DEST] = 1'b1; // $X becomes the hole
					flags[mmix_pkg::FLAG_REL_ADDR] = 1'b1;
					flags[mmix_pkg::FLAG_CTL_CHANGE] = 1'b1;
				end
			end
			default: begin
				op_class = mmix_pkg::cls_trap;
				flags = trap_flags;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/mmix_pkg.sv
/*
 * shared widths, specifier kinds and decode classes of the MMIX dispatch decoder
 * flag bits are bit positions inside flags_t, not masks
 * the local ring is fixed at 256 entries, so slot numbers fit a reg_num_t
 */
`default_nettype none

package mmix_pkg;

	typedef logic [63:0] word_t;      // data and address value
	typedef logic [31:0] inst_t;      // op, xx, yy, zz
	typedef logic [7:0]  reg_num_t;   // register or ring slot number
	typedef logic [61:0] stack_ptr_t; // octabyte count, used for O and S
	typedef logic [7:0]  flags_t;     // operand-use flag set

	// how a specifier value field is read
	typedef enum logic [1:0] {
		spec_none,   // operand not used
		spec_imm,    // value is the operand itself
		spec_global, // value is a global register number
		spec_local   // value is a local ring slot
	} spec_kind_t;

	// internal operation classes, including the two inserted stack operations
	typedef enum logic [3:0] {
		cls_trap,
		cls_addsub,
		cls_cmp,
		cls_shift,
		cls_br,
		cls_ld,
		cls_st,
		cls_logic,
		cls_set,
		cls_inc,
		cls_jmp,
		cls_pushj,
		cls_incrl,    // grows L by one, renaming ring slot O+L
		cls_incgamma  // spills ring slot S to memory
	} op_class_t;

	// positions of the flag bits
	localparam int FLAG_Z_IMM      = 0; // Z field is an immediate
	localparam int FLAG_Z_REG      = 1; // $Z is read
	localparam int FLAG_Y_IMM      = 2; // Y field is an immediate
	localparam int FLAG_Y_REG      = 3; // $Y is read
	localparam int FLAG_X_SRC      = 4; // $X is read
	localparam int FLAG_X_DEST     = 5; // $X is written
	localparam int FLAG_REL_ADDR   = 6; // YZ or XYZ is a relative offset
	localparam int FLAG_CTL_CHANGE = 7; // fetch is redirected here

	// local register ring
	localparam int LRING_SIZE = 256;
	localparam int LRING_MASK = 255;

	// global threshold register
	localparam reg_num_t G_RESET = 8'd255;
	localparam reg_num_t G_MIN   = 8'd32; // $0..$31 always reach the ring

	localparam reg_num_t REG_RJ = 8'd4; // return-jump special register

	// opcodes the decoder looks at directly
	localparam reg_num_t OP_JMP   = 8'hF0;
	localparam reg_num_t OP_PUSHJ = 8'hF2;
	localparam reg_num_t OP_SETH  = 8'hE0;

endpackage

`default_nettype wire
